// File: hdl/core_params.svh
// core parameters for the three-part RV32I pipeline
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define CORE_XLEN 32

// architectural register file
`define CORE_NREGS 32
`define CORE_REG_AW 5

// first fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: hdl/riscv_isa_pkg.sv
// RV32I instruction encoding types for the decoder
package riscv_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [6:0] funct7_t;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // funct3 of the ALU group
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // branch and store codes share the same encodings
    localparam funct3_e F3_BEQ = F3_ADD_SUB;
    localparam funct3_e F3_BNE = F3_SLL;
    localparam funct3_e F3_SW  = F3_SLT;

endpackage

// File: hdl/core_pipe_pkg.sv
// pipeline types shared by decode, buffer and execute
`include "core_params.svh"

package core_pipe_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_XLEN-1:0] addr_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        // lui result is the immediate itself
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_NOP   = 3'd0,
        CLS_ALU   = 3'd1,
        CLS_STORE = 3'd2,
        CLS_BEQ   = 3'd3,
        CLS_BNE   = 3'd4,
        CLS_JAL   = 3'd5
    } op_class_e;

endpackage

// File: hdl/stage_if.sv
// one decoded instruction passed between pipeline parts
`timescale 1ns/1ps

interface stage_if import core_pipe_pkg::*; ();

    logic      valid;
    addr_t     pc;
    op_class_e op_class;
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      use_imm;
    word_t     imm;
    reg_addr_t rd;

    modport src (
        output valid, pc, op_class, alu_op, rs1, rs2,
        output rs1_data, rs2_data, use_imm, imm, rd
    );

    modport dst (
        input valid, pc, op_class, alu_op, rs1, rs2,
        input rs1_data, rs2_data, use_imm, imm, rd
    );

endinterface

// File: hdl/reg_file.sv
// integer register file, two combinational reads and one write
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`CORE_REG_AW-1:0] raddr1_i,
    input  logic [`CORE_REG_AW-1:0] raddr2_i,
    output logic [`CORE_XLEN-1:0]   rdata1_o,
    output logic [`CORE_XLEN-1:0]   rdata2_o,
    input  logic                    we_i,
    input  logic [`CORE_REG_AW-1:0] waddr_i,
    input  logic [`CORE_XLEN-1:0]   wdata_i
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_NREGS];

    // x0 is cleared by reset and never written again
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // no write-through, the buffer forwards instead
    assign rdata1_o = regs_q[raddr1_i];
    assign rdata2_o = regs_q[raddr2_i];

endmodule

// File: hdl/fetch_decode.sv
// program counter, instruction decode and register operand read
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_decode import core_pipe_pkg::*; import riscv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  inst_t     inst_i,
    output addr_t     inst_addr_o,
    input  logic      redirect_i,
    input  addr_t     redirect_pc_i,
    output reg_addr_t rf_raddr1_o,
    output reg_addr_t rf_raddr2_o,
    input  word_t     rf_rdata1_i,
    input  word_t     rf_rdata2_i,
    stage_if.src      dec
);

    addr_t     pc_q;
    opcode_e   opcode;
    funct3_e   funct3;
    funct7_t   funct7;
    op_class_e op_class;
    alu_op_e   alu_op;
    logic      use_imm;
    word_t     imm;

    function automatic alu_op_e alu_from_f3(input funct3_e f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign inst_addr_o = pc_q;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = funct3_e'(inst_i[14:12]);
    assign funct7 = inst_i[31:25];

    always_comb begin
        op_class = CLS_NOP;
        alu_op   = ALU_ADD;
        use_imm  = 1'b0;
        imm      = '0;
        case (opcode)
            OPC_OP: begin
                op_class = CLS_ALU;
                alu_op   = alu_from_f3(funct3, funct7[5]);
            end
            OPC_OP_IMM: begin
                // bit 30 selects srai only, addi has no subtract form
                op_class = CLS_ALU;
                alu_op   = alu_from_f3(funct3, funct7[5] && (funct3 == F3_SRL_SRA));
                use_imm  = 1'b1;
                imm      = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            OPC_LUI: begin
                op_class = CLS_ALU;
                alu_op   = ALU_PASS_B;
                use_imm  = 1'b1;
                imm      = {inst_i[31:12], 12'b0};
            end
            OPC_STORE: begin
                if (funct3 == F3_SW) begin
                    op_class = CLS_STORE;
                    use_imm  = 1'b1;
                    imm      = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
                end
            end
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    op_class = CLS_BEQ;
                end else if (funct3 == F3_BNE) begin
                    op_class = CLS_BNE;
                end
                imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                op_class = CLS_JAL;
                imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                op_class = CLS_NOP;
            end
        endcase
    end

    assign rf_raddr1_o = inst_i[19:15];
    assign rf_raddr2_o = inst_i[24:20];

    // wrong-path instruction is dropped while the pc redirects
    assign dec.valid    = !redirect_i;
    assign dec.pc       = pc_q;
    assign dec.op_class = op_class;
    assign dec.alu_op   = alu_op;
    assign dec.rs1      = inst_i[19:15];
    assign dec.rs2      = inst_i[24:20];
    assign dec.rs1_data = rf_rdata1_i;
    assign dec.rs2_data = rf_rdata2_i;
    assign dec.use_imm  = use_imm;
    assign dec.imm      = imm;
    assign dec.rd       = inst_i[11:7];

endmodule

// File: hdl/id_ex_buffer.sv
// decode to execute register with write-back operand bypass
`timescale 1ns/1ps

module id_ex_buffer import core_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      wb_en_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    stage_if.dst      dec,
    stage_if.src      exe
);

    logic fwd1;
    logic fwd2;

    // register file is written this same edge, so take the new value here
    assign fwd1 = wb_en_i && (wb_rd_i != '0) && (wb_rd_i == dec.rs1);
    assign fwd2 = wb_en_i && (wb_rd_i != '0) && (wb_rd_i == dec.rs2);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        exe.pc       <= dec.pc;
        exe.op_class <= dec.op_class;
        exe.alu_op   <= dec.alu_op;
        exe.rs1      <= dec.rs1;
        exe.rs2      <= dec.rs2;
        exe.rs1_data <= fwd1 ? wb_data_i : dec.rs1_data;
        exe.rs2_data <= fwd2 ? wb_data_i : dec.rs2_data;
        exe.use_imm  <= dec.use_imm;
        exe.imm      <= dec.imm;
        exe.rd       <= dec.rd;
    end

endmodule

// File: hdl/execute_unit.sv
// ALU, branch resolution, store port and register write-back
`timescale 1ns/1ps
`include "core_params.svh"

module execute_unit import core_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    stage_if.dst      exe,
    output logic      redirect_o,
    output addr_t     redirect_pc_o,
    output logic      wb_en_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    output logic      mem_w_enable_o,
    output addr_t     mem_w_addr_o,
    output word_t     mem_w_data_o
);

    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    logic [4:0] shamt;
    logic       equal;
    logic       taken;
    logic       is_jal;
    logic       is_store;

    assign op_a  = exe.rs1_data;
    assign op_b  = exe.use_imm ? exe.imm : exe.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (exe.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> shamt);
            ALU_SLT:    alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // branches always compare the two registers
    assign equal    = (exe.rs1_data == exe.rs2_data);
    assign is_jal   = (exe.op_class == CLS_JAL);
    assign is_store = exe.valid && (exe.op_class == CLS_STORE);

    assign taken = exe.valid &&
                   (((exe.op_class == CLS_BEQ) && equal) ||
                    ((exe.op_class == CLS_BNE) && !equal) ||
                    is_jal);

    assign redirect_o    = taken;
    assign redirect_pc_o = exe.pc + exe.imm;

    // link value for jal, alu result otherwise
    assign wb_en_o   = exe.valid && ((exe.op_class == CLS_ALU) || is_jal);
    assign wb_rd_o   = exe.rd;
    assign wb_data_o = is_jal ? exe.pc + 32'd4 : alu_res;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_w_enable_o <= 1'b0;
        end else begin
            mem_w_enable_o <= is_store;
        end
    end

    // store address comes out of the adder as rs1 plus offset
    always_ff @(posedge clk) begin
        mem_w_addr_o <= alu_res;
        mem_w_data_o <= exe.rs2_data;
    end

endmodule

// File: hdl/rv_core_top.sv
// RV32I core top, fetch/decode, buffer and execute parts
`timescale 1ns/1ps

module rv_core_top import core_pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  riscv_isa_pkg::inst_t inst_i,
    output addr_t                inst_addr_o,
    output logic                 mem_w_enable_o,
    output addr_t                mem_w_addr_o,
    output word_t                mem_w_data_o
);

    logic      redirect;
    addr_t     redirect_pc;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    stage_if dec_bus ();
    stage_if exe_bus ();

    fetch_decode u_fetch_decode (
        .clk           (clk          ),
        .rst_n_i       (rst_n_i      ),
        .inst_i        (inst_i       ),
        .inst_addr_o   (inst_addr_o  ),
        .redirect_i    (redirect     ),
        .redirect_pc_i (redirect_pc  ),
        .rf_raddr1_o   (rf_raddr1    ),
        .rf_raddr2_o   (rf_raddr2    ),
        .rf_rdata1_i   (rf_rdata1    ),
        .rf_rdata2_i   (rf_rdata2    ),
        .dec           (dec_bus.src  )
    );

    reg_file u_reg_file (
        .clk      (clk       ),
        .rst_n_i  (rst_n_i   ),
        .raddr1_i (rf_raddr1 ),
        .raddr2_i (rf_raddr2 ),
        .rdata1_o (rf_rdata1 ),
        .rdata2_o (rf_rdata2 ),
        .we_i     (wb_en     ),
        .waddr_i  (wb_rd     ),
        .wdata_i  (wb_data   )
    );

    id_ex_buffer u_id_ex_buffer (
        .clk       (clk          ),
        .rst_n_i   (rst_n_i      ),
        .wb_en_i   (wb_en        ),
        .wb_rd_i   (wb_rd        ),
        .wb_data_i (wb_data      ),
        .dec       (dec_bus.dst  ),
        .exe       (exe_bus.src  )
    );

    execute_unit u_execute_unit (
        .clk            (clk            ),
        .rst_n_i        (rst_n_i        ),
        .exe            (exe_bus.dst    ),
        .redirect_o     (redirect       ),
        .redirect_pc_o  (redirect_pc    ),
        .wb_en_o        (wb_en          ),
        .wb_rd_o        (wb_rd          ),
        .wb_data_o      (wb_data        ),
        .mem_w_enable_o (mem_w_enable_o ),
        .mem_w_addr_o   (mem_w_addr_o   ),
        .mem_w_data_o   (mem_w_data_o   )
    );

endmodule

// File: testbench/tb_rv_core_top.sv
// testbench that runs a hex program on the RV32I core and checks every store
`timescale 1ns/1ps

module tb_rv_core_top import core_pipe_pkg::*; ();

    localparam int          MEM_AW    = 7;
    localparam int          MEM_WORDS = 1 << MEM_AW;
    localparam logic [31:0] NOP_INST  = 32'h0000_0013;
    localparam logic [31:0] HALT_INST = 32'h0000_006f;

    logic        clk = 1'b0;
    logic        rst_n_i = 1'b0;
    logic [31:0] inst_i = NOP_INST;
    addr_t       inst_addr_o;
    logic        mem_w_enable_o;
    addr_t       mem_w_addr_o;
    word_t       mem_w_data_o;

    // program, then store count, then address and data pairs
    logic [31:0] mem [MEM_WORDS];
    int          prog_len = 0;
    int          store_cnt = 0;
    int          seen = 0;

    rv_core_top u_dut (
        .clk            (clk            ),
        .rst_n_i        (rst_n_i        ),
        .inst_i         (inst_i         ),
        .inst_addr_o    (inst_addr_o    ),
        .mem_w_enable_o (mem_w_enable_o ),
        .mem_w_addr_o   (mem_w_addr_o   ),
        .mem_w_data_o   (mem_w_data_o   )
    );

    always #5 clk = ~clk;

    // the first jump to itself ends the program
    function automatic int program_length();
        int len;
        len = 0;
        for (int i = MEM_WORDS - 1; i >= 0; i--) begin
            if (mem[i[MEM_AW-1:0]] === HALT_INST) begin
                len = i + 1;
            end
        end
        return len;
    endfunction

    function automatic logic [31:0] fetch_word(input addr_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len) begin
            return mem[idx[MEM_AW-1:0]];
        end else begin
            return NOP_INST;
        end
    endfunction

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "data mismatch");
        end
    endtask

    // instruction memory answers shortly after the edge that moves the pc
    always @(posedge clk) begin
        #1;
        inst_i = fetch_word(inst_addr_o);
    end

    // store port is stable at the falling edge
    always @(negedge clk) begin
        int ptr;
        ptr = prog_len + 1 + 2 * seen;
        if (mem_w_enable_o === 1'b1) begin
            if (seen >= store_cnt) begin
                $display("store to %h arrived after all expected stores", mem_w_addr_o);
                $display("Simulation failed");
                $fatal(1, "extra store");
            end else begin
                check_addr("mem_w_addr_o", mem[ptr[MEM_AW-1:0]], mem_w_addr_o);
                check_word("mem_w_data_o", mem[ptr[MEM_AW-1:0] + 7'd1], mem_w_data_o);
                seen++;
            end
        end
    end

    initial begin
        $readmemh("testbench/rv_core_testdata.hex", mem);
        prog_len = program_length();
        if (prog_len == 0) begin
            $display("the data file holds no program ending in a jump to itself");
            $display("Simulation failed");
            $fatal(1, "bad data file");
        end
        store_cnt = mem[prog_len[MEM_AW-1:0]];
        repeat (2) @(posedge clk);
        #1;
        check_addr("inst_addr_o", 32'h0000_0000, inst_addr_o);
        rst_n_i = 1'b1;
        wait (seen == store_cnt);
        repeat (20) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

    // limit grows with the program and the number of stores
    initial begin
        #1;
        repeat ((prog_len + store_cnt) * 8) @(posedge clk);
        $display("timeout, only %0d of %0d expected stores arrived", seen, store_cnt);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: rv_core_top.f
+incdir+hdl
hdl/riscv_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/stage_if.sv
hdl/reg_file.sv
hdl/fetch_decode.sv
hdl/id_ex_buffer.sv
hdl/execute_unit.sv
hdl/rv_core_top.sv
testbench/tb_rv_core_top.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timescale 1ns/1ps -f rv_core_top.f \
		--top-module tb_rv_core_top -Mdir $(OBJ_DIR) -o tb_rv_core_top

run: compile
	@out=$$(./$(OBJ_DIR)/tb_rv_core_top 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/rv_core_testdata.hex
// program words, one per line, the first jump to itself ends the program
// then the store count, then one line per store: address data
800000B7 // lui   x1, 0x80000
FFB00113 // addi  x2, x0, -5
00700193 // addi  x3, x0, 7
4030D233 // sra   x4, x1, x3
10402023 // sw    x4, 0x100(x0)
00312333 // slt   x6, x2, x3
0021B3B3 // sltu  x7, x3, x2
0030D2B3 // srl   x5, x1, x3
40218433 // sub   x8, x3, x2
005444B3 // xor   x9, x8, x5
0074E4B3 // or    x9, x9, x7
006484B3 // add   x9, x9, x6
0024F533 // and   x10, x9, x2
003515B3 // sll   x11, x10, x3
10B02223 // sw    x11, 0x104(x0)
4045D613 // srai  x12, x11, 4
30066613 // ori   x12, x12, 0x300
00865613 // srli  x12, x12, 8
FFE67613 // andi  x12, x12, -2
10C02423 // sw    x12, 0x108(x0)
00312693 // slti  x13, x2, 3
00313713 // sltiu x14, x2, 3
00169793 // slli  x15, x13, 1
00E7E7B3 // or    x15, x15, x14
5A07C793 // xori  x15, x15, 0x5a0
10F02623 // sw    x15, 0x10c(x0)
00500013 // addi  x0, x0, 5
10002823 // sw    x0, 0x110(x0)
00218463 // beq   x3, x2, +8 not taken
10302A23 // sw    x3, 0x114(x0)
00219463 // bne   x3, x2, +8 taken
10202C23 // sw    x2, 0x118(x0) skipped
00318463 // beq   x3, x3, +8 taken
10202E23 // sw    x2, 0x11c(x0) skipped
0080086F // jal   x16, +8
12202023 // sw    x2, 0x120(x0) skipped
11002C23 // sw    x16, 0x118(x0)
0000006F // jal   x0, 0
00000007
00000100 FF000000
00000104 80000500
00000108 00F80002
0000010C 000005A2
00000110 00000000
00000114 00000007
00000118 0000008C
